// ==== include/conv_kernel.svh ====
`ifndef CONV_KERNEL_SVH
`define CONV_KERNEL_SVH

// ##########################################################
// 3x3 kernel, row-major k0..k8, centre weight at tap 4
// ##########################################################

localparam pixel_t KERNEL_W [NUM_TAPS] = '{
  20'sh0A89E,
  20'sh092D5,
  20'sh06D43,
  20'sh01004,
  20'shF8F71,  // negative weights from here to k8.
  20'shF6E54,
  20'shFA6D7,
  20'shFC834,
  20'shFAC19
};

localparam pixel_t CONV_BIAS = 20'sh01310;

`endif

// ==== design/conv_pkg.sv ====
package conv_pkg;

  // ##########################################################
  // data types
  // ##########################################################

  // signed fixed point, 4 integer and 16 fraction bits.
  typedef logic signed [19:0] pixel_t;

  // product sum of one window, kept at full 40 bits.
  typedef logic signed [39:0] acc_t;

  // tap position 0..8, row-major, 4 is the centre pixel.
  typedef logic [3:0] tap_idx_t;

  // ##########################################################
  // window and result scaling
  // ##########################################################

  localparam int NUM_TAPS = 9;

  localparam int ROUND_BIT = 15;  // half an lsb of the result.
  localparam int FRAC_LSB  = 16;  // result lsb inside the accumulator.

  `include "conv_kernel.svh"

endpackage

// ==== design/window_if.sv ====
`timescale 1ns/1ps

// fetcher to holding register.
interface fetch_if #(
  parameter int IMG_BITS = 6
) ();
  import conv_pkg::*;

  logic                  load;
  pixel_t [NUM_TAPS-1:0] taps;
  logic [2*IMG_BITS-1:0] center_addr;
  logic                  last;
  logic                  full;

  modport producer (output load, taps, center_addr, last, input full);
  modport buffer (input load, taps, center_addr, last, output full);
endinterface

// holding register to arithmetic.
interface tap_if #(
  parameter int IMG_BITS = 6
) ();
  import conv_pkg::*;

  logic                  valid;
  pixel_t [NUM_TAPS-1:0] taps;
  logic [2*IMG_BITS-1:0] center_addr;
  logic                  last;
  logic                  take;

  modport buffer (output valid, taps, center_addr, last, input take);
  modport consumer (input valid, taps, center_addr, last, output take);
endinterface

// ==== design/window_fetch.sv ====
`timescale 1ns/1ps

module window_fetch #(
  parameter int IMG_BITS = 6
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ready,
  input  conv_pkg::pixel_t      idata,
  input  logic                  run_done,
  output logic                  busy,
  output logic [2*IMG_BITS-1:0] iaddr,
  fetch_if.producer             fetch
);
  import conv_pkg::*;

  // the first in-image tap of pixel (0,0) is its centre.
  localparam tap_idx_t CENTER_TAP = tap_idx_t'(4);
  localparam logic [IMG_BITS-1:0] EDGE = '1;  // index of the last row and column.

  typedef enum logic [1:0] {
    IDLE,
    GATHER,
    OFFER
  } fetch_state_t;

  fetch_state_t          state;
  logic [IMG_BITS-1:0]   row;
  logic [IMG_BITS-1:0]   col;
  tap_idx_t              tap;
  pixel_t [NUM_TAPS-1:0] win;
  logic [IMG_BITS-1:0]   nxt_row;
  logic [IMG_BITS-1:0]   nxt_col;
  tap_idx_t              nxt_tap;
  tap_idx_t              entry_tap;
  logic                  start;

  // ##########################################################
  // tap geometry
  // ##########################################################

  function automatic logic tap_inside(input tap_idx_t t,
                                      input logic [IMG_BITS-1:0] r,
                                      input logic [IMG_BITS-1:0] c);
    logic [1:0] tr;
    logic [1:0] tc;
    tr = 2'(t / 4'd3);
    tc = 2'(t % 4'd3);
    return !((tr == 2'd0 && r == '0) || (tr == 2'd2 && r == EDGE) ||
             (tc == 2'd0 && c == '0) || (tc == 2'd2 && c == EDGE));
  endfunction

  // lowest in-image tap at or above from, NUM_TAPS when there is none.
  function automatic tap_idx_t first_tap(input tap_idx_t from,
                                         input logic [IMG_BITS-1:0] r,
                                         input logic [IMG_BITS-1:0] c);
    tap_idx_t found;
    found = tap_idx_t'(NUM_TAPS);
    for (int i = NUM_TAPS - 1; i >= 0; i--) begin
      if (tap_idx_t'(i) >= from && tap_inside(tap_idx_t'(i), r, c)) begin
        found = tap_idx_t'(i);
      end
    end
    return found;
  endfunction

  function automatic logic [2*IMG_BITS-1:0] tap_addr(input tap_idx_t t,
                                                     input logic [IMG_BITS-1:0] r,
                                                     input logic [IMG_BITS-1:0] c);
    logic [1:0] tr;
    logic [1:0] tc;
    tr = 2'(t / 4'd3);
    tc = 2'(t % 4'd3);
    return {r + IMG_BITS'(tr) - IMG_BITS'(1), c + IMG_BITS'(tc) - IMG_BITS'(1)};
  endfunction

  assign start     = (state == IDLE) && !busy && ready;
  assign nxt_col   = col + 1'b1;
  assign nxt_row   = (col == EDGE) ? row + 1'b1 : row;
  assign nxt_tap   = first_tap(tap + 1'b1, row, col);
  assign entry_tap = first_tap(tap_idx_t'(0), nxt_row, nxt_col);

  // tap only ever points at an in-image neighbour, so the address is always valid.
  assign iaddr = tap_addr(tap, row, col);

  assign fetch.load        = (state == OFFER) && !fetch.full;
  assign fetch.taps        = win;
  assign fetch.center_addr = {row, col};
  assign fetch.last        = (row == EDGE) && (col == EDGE);

  // ##########################################################
  // run control and counters
  // ##########################################################

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= IDLE;
      row   <= '0;
      col   <= '0;
      tap   <= CENTER_TAP;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= GATHER;
          end
        end
        GATHER: begin
          if (nxt_tap == tap_idx_t'(NUM_TAPS)) begin
            state <= OFFER;  // tap stays put, so iaddr holds while waiting.
          end else begin
            tap <= nxt_tap;
          end
        end
        OFFER: begin
          if (fetch.load) begin
            row   <= nxt_row;  // wraps to 0 after the last pixel.
            col   <= nxt_col;
            tap   <= entry_tap;
            state <= fetch.last ? IDLE : GATHER;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
    end else if (run_done) begin
      busy <= 1'b0;
    end
  end

  // out-of-image taps are never written and keep the zero from the clear.
  always_ff @(posedge clk) begin
    if (start || fetch.load) begin
      win <= '0;
    end else if (state == GATHER) begin
      win[tap] <= idata;
    end
  end

endmodule

// ==== design/window_buffer.sv ====
`timescale 1ns/1ps

module window_buffer #(
  parameter int IMG_BITS = 6
) (
  input  logic     clk,
  input  logic     reset,
  fetch_if.buffer  fetch,
  tap_if.buffer    taps_out
);
  import conv_pkg::*;

  logic                  full;
  pixel_t [NUM_TAPS-1:0] taps_q;
  logic [2*IMG_BITS-1:0] center_q;
  logic                  last_q;

  // a load in the same cycle as a take keeps the entry occupied.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      full <= 1'b0;
    end else if (fetch.load) begin
      full <= 1'b1;
    end else if (taps_out.take) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch.load) begin
      taps_q   <= fetch.taps;
      center_q <= fetch.center_addr;
      last_q   <= fetch.last;
    end
  end

  assign fetch.full = full;

  assign taps_out.valid       = full;
  assign taps_out.taps        = taps_q;
  assign taps_out.center_addr = center_q;
  assign taps_out.last        = last_q;

endmodule

// ==== design/conv_mac.sv ====
`timescale 1ns/1ps

module conv_mac #(
  parameter int IMG_BITS = 6
) (
  input  logic                  clk,
  input  logic                  reset,
  tap_if.consumer               win,
  output logic                  cwr,
  output logic [2*IMG_BITS-1:0] caddr_wr,
  output conv_pkg::pixel_t      cdata_wr,
  output logic                  run_done
);
  import conv_pkg::*;

  localparam int PW = $bits(pixel_t);

  typedef enum logic [1:0] {
    S_TAKE,
    S_ROUND,
    S_WRITE
  } mac_state_t;

  mac_state_t state;
  acc_t       acc;
  pixel_t     res;
  logic       last_q;

  // ##########################################################
  // product sum
  // ##########################################################

  function automatic acc_t window_sum(input pixel_t [NUM_TAPS-1:0] taps);
    acc_t s;
    s = '0;
    for (int i = 0; i < NUM_TAPS; i++) begin
      s += acc_t'(taps[i]) * acc_t'(KERNEL_W[i]);  // both sign-extended to 40 bits.
    end
    return s;
  endfunction

  assign win.take = (state == S_TAKE) && win.valid;

  // the sum is formed straight from the buffer outputs on the take edge.
  always_ff @(posedge clk) begin
    if (win.take) begin
      acc <= window_sum(win.taps);
    end
  end

  // ##########################################################
  // sequence: take, round with bias, write
  // ##########################################################

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= S_TAKE;
      caddr_wr <= '0;
      res      <= '0;
      last_q   <= 1'b0;
    end else begin
      case (state)
        S_TAKE: begin
          if (win.take) begin
            caddr_wr <= win.center_addr;
            last_q   <= win.last;
            state    <= S_ROUND;
          end
        end
        S_ROUND: begin
          res   <= pixel_t'(acc[FRAC_LSB +: PW]) + pixel_t'(acc[ROUND_BIT]) + CONV_BIAS;
          state <= S_WRITE;
        end
        S_WRITE: begin
          state <= S_TAKE;
        end
        default: state <= S_TAKE;
      endcase
    end
  end

  assign cwr      = (state == S_WRITE);
  assign run_done = cwr && last_q;  // busy drops on the following edge.
  assign cdata_wr = res[PW-1] ? '0 : res;  // relu.

endmodule

// ==== design/conv_top.sv ====
`timescale 1ns/1ps

module conv_top #(
  parameter int IMG_BITS = 6
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ready,
  input  conv_pkg::pixel_t      idata,
  output logic                  busy,
  output logic [2*IMG_BITS-1:0] iaddr,
  output logic                  cwr,
  output logic [2*IMG_BITS-1:0] caddr_wr,
  output conv_pkg::pixel_t      cdata_wr
);

  logic run_done;

  fetch_if #(.IMG_BITS(IMG_BITS)) fetch_bus ();
  tap_if #(.IMG_BITS(IMG_BITS)) tap_bus ();

  // fetcher gathers the next window while the arithmetic works on the buffered one.
  window_fetch #(
    .IMG_BITS(IMG_BITS)
  ) u_fetch (
    .clk(clk),
    .reset(reset),
    .ready(ready),
    .idata(idata),
    .run_done(run_done),
    .busy(busy),
    .iaddr(iaddr),
    .fetch(fetch_bus)
  );

  window_buffer #(
    .IMG_BITS(IMG_BITS)
  ) u_buffer (
    .clk(clk),
    .reset(reset),
    .fetch(fetch_bus),
    .taps_out(tap_bus)
  );

  conv_mac #(
    .IMG_BITS(IMG_BITS)
  ) u_mac (
    .clk(clk),
    .reset(reset),
    .win(tap_bus),
    .cwr(cwr),
    .caddr_wr(caddr_wr),
    .cdata_wr(cdata_wr),
    .run_done(run_done)
  );

endmodule

// ==== verif/conv_top_chk.sv ====
`timescale 1ns/1ps

module conv_top_chk #(
  parameter int IMG_BITS = 6
) (
  input logic                  clk,
  input logic                  reset,
  input logic                  ready,
  input logic                  busy,
  input logic                  cwr,
  input logic [2*IMG_BITS-1:0] caddr_wr
);

  localparam logic [2*IMG_BITS-1:0] LAST_ADDR = '1;

  logic [2*IMG_BITS-1:0] prev_addr;

  // starts at the last address so the first write of a run must land on zero.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      prev_addr <= '1;
    end else if (cwr) begin
      prev_addr <= caddr_wr;
    end
  end

  // ##########################################################
  // write strobe and run level
  // ##########################################################

  write_in_run: assert property (@(posedge clk) disable iff (reset) cwr |-> busy)
    else $error("cwr high while busy is low");

  write_single: assert property (@(posedge clk) disable iff (reset) cwr |=> !cwr)
    else $error("cwr high in two successive cycles");

  write_order: assert property (@(posedge clk) disable iff (reset)
                                cwr |-> caddr_wr == prev_addr + 1'b1)
    else $error("caddr_wr did not advance by one");

  busy_end: assert property (@(posedge clk) disable iff (reset)
                             $fell(busy) |-> $past(cwr && caddr_wr == LAST_ADDR))
    else $error("busy fell without a write to the last address");

  busy_start: assert property (@(posedge clk) disable iff (reset)
                               $rose(busy) |-> $past(ready))
    else $error("busy rose without ready");

endmodule

bind conv_top conv_top_chk #(
  .IMG_BITS(IMG_BITS)
) u_chk (
  .clk(clk),
  .reset(reset),
  .ready(ready),
  .busy(busy),
  .cwr(cwr),
  .caddr_wr(caddr_wr)
);

// ==== verif/tb_conv.sv ====
`timescale 1ns/1ps

module tb_conv;
  import conv_pkg::*;

  localparam int IMG_BITS       = 6;
  localparam int SIDE           = 1 << IMG_BITS;
  localparam int NPIX           = SIDE * SIDE;
  localparam int PIX_CYCLES     = 13;  // worst case per pixel with a full window.
  localparam int TIMEOUT_CYCLES = 2 * NPIX * PIX_CYCLES * 9 / 8;

  // corners first, then one pixel in the middle of each edge.
  localparam int PAD_ROW [8] = '{0, 0, SIDE-1, SIDE-1, 0, SIDE/2, SIDE-1, SIDE/2};
  localparam int PAD_COL [8] = '{0, SIDE-1, 0, SIDE-1, SIDE/2, 0, SIDE/2, SIDE-1};

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  ready;
  pixel_t                idata;
  logic                  busy;
  logic [2*IMG_BITS-1:0] iaddr;
  logic                  cwr;
  logic [2*IMG_BITS-1:0] caddr_wr;
  pixel_t                cdata_wr;

  pixel_t      img [NPIX];
  pixel_t      got_mem [NPIX];
  int          wr_count [NPIX];
  logic [15:0] lfsr = 16'd36801;
  int          cycles = 0;
  int          test_errors = 0;
  int          pass_count = 0;
  int          fail_count = 0;

  conv_top #(
    .IMG_BITS(IMG_BITS)
  ) uut (
    .clk(clk),
    .reset(reset),
    .ready(ready),
    .idata(idata),
    .busy(busy),
    .iaddr(iaddr),
    .cwr(cwr),
    .caddr_wr(caddr_wr),
    .cdata_wr(cdata_wr)
  );

  always #10 clk = ~clk;

  assign idata = img[iaddr];  // image memory answers in the same cycle.

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: no result after %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  // ##########################################################
  // stimulus and reference
  // ##########################################################

  // x^16 + x^14 + x^13 + x^11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
  endtask

  // 17 random bits shifted down by one gives pixels in [-1, 1).
  task automatic load_image();
    int raw;
    for (int a = 0; a < NPIX; a++) begin
      take_bits(17, raw);
      img[a] = pixel_t'(raw - 65536);
    end
  endtask

  function automatic pixel_t ref_sum(input int r, input int c);
    longint sum;
    longint q;
    int     rr;
    int     cc;
    int     k;
    sum = 0;
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        rr = r + dr;
        cc = c + dc;
        k  = (dr + 1) * 3 + (dc + 1);
        if (rr >= 0 && rr < SIDE && cc >= 0 && cc < SIDE) begin
          sum += longint'(img[rr * SIDE + cc]) * longint'(KERNEL_W[k]);
        end
      end
    end
    q = (sum >>> 16) + longint'(sum[15]) + longint'(CONV_BIAS);
    return pixel_t'(q);
  endfunction

  function automatic pixel_t relu(input pixel_t v);
    return (v < 0) ? pixel_t'(0) : v;
  endfunction

  // raises ready, captures every write and returns once busy has fallen.
  task automatic run_image();
    bit seen_busy;
    bit done;
    for (int a = 0; a < NPIX; a++) begin
      got_mem[a]  = '0;
      wr_count[a] = 0;
    end
    seen_busy = 1'b0;
    done      = 1'b0;
    @(posedge clk);
    #2 ready = 1'b1;
    while (!done) begin
      @(negedge clk);
      if (cwr) begin
        got_mem[caddr_wr] = cdata_wr;
        wr_count[caddr_wr]++;
      end
      if (busy) begin
        seen_busy = 1'b1;
      end else if (seen_busy) begin
        done = 1'b1;
      end
      if (!done) begin
        @(posedge clk);
        #2;
        if (seen_busy) begin
          ready = 1'b0;
        end
      end
    end
  endtask

  // ##########################################################
  // checks
  // ##########################################################

  task automatic check_pixel(input string test, input int r, input int c);
    int     addr;
    pixel_t exp;
    addr = r * SIDE + c;
    exp  = relu(ref_sum(r, c));
    assert (wr_count[addr] == 1) else begin
      $display("%s: address %0d was written %0d times instead of once",
               test, addr, wr_count[addr]);
      test_errors++;
    end
    assert (got_mem[addr] == exp) else begin
      $display("MISMATCH %s at address %0d: expected %05h, actual %05h",
               test, addr, exp, got_mem[addr]);
      test_errors++;
    end
  endtask

  task automatic check_image(input string test);
    for (int r = 0; r < SIDE; r++) begin
      for (int c = 0; c < SIDE; c++) begin
        check_pixel(test, r, c);
      end
    end
  endtask

  task automatic finish_test(input string test);
    if (test_errors == 0) begin
      pass_count++;
      $display("test %s: ok", test);
    end else begin
      fail_count++;
      $display("test %s: %0d errors", test, test_errors);
    end
    test_errors = 0;
  endtask

  initial begin
    int     negatives;
    pixel_t pre;
    reset = 1'b1;
    ready = 1'b0;
    load_image();

    repeat (3) begin
      @(negedge clk);
      assert (!busy && !cwr) else begin
        $display("reset: busy or cwr high during reset");
        test_errors++;
      end
    end
    @(posedge clk);
    #2 reset = 1'b0;
    @(negedge clk);
    assert (iaddr == '0 && caddr_wr == '0 && cdata_wr == '0) else begin
      $display("reset: address or data outputs not zero after reset");
      test_errors++;
    end
    repeat (10) begin
      @(negedge clk);
      assert (!busy && !cwr) else begin
        $display("reset: busy or cwr high without ready");
        test_errors++;
      end
    end
    finish_test("reset");

    run_image();
    check_image("full_image");
    finish_test("full_image");

    for (int i = 0; i < 8; i++) begin
      check_pixel("zero_padding", PAD_ROW[i], PAD_COL[i]);
    end
    finish_test("zero_padding");

    negatives = 0;
    for (int a = 0; a < NPIX; a++) begin
      pre = ref_sum(a / SIDE, a % SIDE);
      if (pre < 0) begin
        negatives++;
        assert (got_mem[a] == '0) else begin
          $display("MISMATCH relu at address %0d: expected %05h, actual %05h",
                   a, pixel_t'(0), got_mem[a]);
          test_errors++;
        end
      end
    end
    assert (negatives > 0) else begin
      $display("relu: no pixel with a negative sum occurred in the image");
      test_errors++;
    end
    finish_test("relu");

    load_image();
    run_image();
    check_image("second_run");
    finish_test("second_run");

    $display("tests: %0d ok, %0d failing", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+include
design/conv_pkg.sv
design/window_if.sv
design/window_fetch.sv
design/window_buffer.sv
design/conv_mac.sv
design/conv_top.sv
verif/conv_top_chk.sv
verif/tb_conv.sv

// ==== run.sh ====
#!/bin/sh
# Build the convolution testbench with Verilator, run it and grade the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_conv -f build.f -o tb_conv \
  && ./obj_dir/tb_conv > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation stopped with an error"; exit 1; }

cat sim.log
grep -q "^Testbench passed$" sim.log && exit 0 || exit 1
